/* logic/ih_settings.svh */
`ifndef IH_SETTINGS_SVH
`define IH_SETTINGS_SVH

// Width of the input bank that fires on rising edges.
`define IH_INPUT_WIDTH 16

// Width of the level-triggered GPIO bank and its mask.
`define IH_GPIO_WIDTH 8

// Width of the interval counter and of the programmed period.
`define IH_TIMER_WIDTH 32

// Number of flops every asynchronous pin passes before use.
`define IH_SYNC_STAGES 2

`endif

/* logic/ih_irq_pkg.sv */
`include "ih_settings.svh"

package ih_irq_pkg;

    // Source reported with a request. The order of the values follows the
    // priority order, highest first.
    typedef enum logic [1:0] {
        timer_is    = 2'd0,
        input_is    = 2'd1,
        gpio_is     = 2'd2,
        external_is = 2'd3
    } irq_source_e;

    // The interval timer is either stopped or counting toward its period.
    typedef enum logic {
        idle     = 1'b0,
        counting = 1'b1
    } timer_state_e;

    // One bit per cause, valid for a single cycle.
    // Any set bit schedules a request.
    typedef struct packed {
        logic timer_fire;
        logic input_fire;
        logic gpio_fire;
        logic external_fire;
    } irq_events_t;

endpackage

/* logic/ih_io_pkg.sv */
`include "ih_settings.svh"

package ih_io_pkg;

    // Every asynchronous level that enters the handler, kept together so
    // that one synchronizer treats them all alike.
    typedef struct packed {
        logic [`IH_INPUT_WIDTH-1:0] input_lines;
        logic                       ext_pin;
        logic [`IH_GPIO_WIDTH-1:0]  gpio_pins;
    } pin_bundle_t;

    // Rising-edge pulses from the edge detector bank.
    // The external pin sits in the lowest bit, next to the input lines.
    typedef struct packed {
        logic [`IH_INPUT_WIDTH-1:0] input_rise;
        logic                       ext_rise;
    } edge_bundle_t;

endpackage

/* logic/input_synchronizer.sv */
`include "ih_settings.svh"

module input_synchronizer
    import ih_io_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  pin_bundle_t pins_raw,
    output pin_bundle_t pins_sync
);

    // Stage 0 takes the raw pins and may go metastable; the last stage is
    // the only one the rest of the design looks at.
    pin_bundle_t sync_q [`IH_SYNC_STAGES];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `IH_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= pins_raw;
            for (int i = 1; i < `IH_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1]; // Shift one stage down the chain.
            end
        end
    end

    assign pins_sync = sync_q[`IH_SYNC_STAGES-1];

endmodule

/* logic/edge_detector.sv */
module edge_detector (
    input  logic clk,
    input  logic nrst,
    input  logic data_in,
    output logic rising_edge,
    output logic held
);

    logic prev_q; // Level seen at the last clock edge.

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            prev_q <= 1'b0;
        end else begin
            prev_q <= data_in;
        end
    end

    // A rise lasts exactly one cycle, since prev_q catches up at the next edge.
    assign rising_edge = data_in & ~prev_q;

    // High from the second cycle of a high level onward.
    assign held = data_in & prev_q;

endmodule

/* logic/interval_timer.sv */
`include "ih_settings.svh"

module interval_timer
    import ih_irq_pkg::*;
(
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       enable,
    input  logic [`IH_TIMER_WIDTH-1:0] timer_max,
    output logic                       int_fire
);

    timer_state_e               state_q;
    logic [`IH_TIMER_WIDTH-1:0] count_q;
    logic                       at_max;

    assign at_max = (count_q == timer_max);

    // The count restarts from zero on the cycle after it reaches timer_max,
    // so one period is timer_max+1 cycles long.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= idle;
            count_q <= '0;
        end else begin
            case (state_q)
                idle: begin
                    count_q <= '0;
                    if (enable) begin
                        state_q <= counting;
                    end
                end
                counting: begin
                    if (!enable) begin
                        state_q <= idle; // Dropping enable forgets the partial period.
                        count_q <= '0;
                    end else if (at_max) begin
                        count_q <= '0;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= idle;
                    count_q <= '0;
                end
            endcase
        end
    end

    assign int_fire = (state_q == counting) && at_max;

endmodule

/* logic/interrupt_arbiter.sv */
`include "ih_settings.svh"

module interrupt_arbiter
    import ih_irq_pkg::*;
    import ih_io_pkg::*;
(
    input  logic                      clk,
    input  logic                      nrst,
    input  edge_bundle_t              edges,
    input  logic [`IH_GPIO_WIDTH-1:0] gpio_sync,
    input  logic [`IH_GPIO_WIDTH-1:0] gpio_mask,
    input  logic                      timer_fire,
    input  logic                      input_enable,
    input  logic                      interrupts_enabled,
    input  logic                      interrupt_ack,
    output logic                      interrupt_requested,
    output irq_source_e               interrupt_source
);

    irq_events_t events;
    irq_source_e next_source;
    logic        scheduled;

    always_comb begin
        events.timer_fire    = timer_fire;
        events.input_fire    = input_enable & (|edges.input_rise);
        events.gpio_fire     = |(gpio_sync & gpio_mask); // Level sensitive.
        events.external_fire = edges.ext_rise;
    end

    assign scheduled = |events;

    // Fixed priority: timer, then input bank, then GPIO, then external pin.
    always_comb begin
        if (events.timer_fire) begin
            next_source = timer_is;
        end else if (events.input_fire) begin
            next_source = input_is;
        end else if (events.gpio_fire) begin
            next_source = gpio_is;
        end else if (events.external_fire) begin
            next_source = external_is;
        end else begin
            next_source = timer_is;
        end
    end

    // The request stays up until the CPU acknowledges it. An event in the
    // acknowledge cycle keeps it up for the new cause.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            interrupt_requested <= 1'b0;
            interrupt_source    <= timer_is;
        end else begin
            interrupt_requested <= interrupts_enabled
                                   & ((interrupt_requested & ~interrupt_ack) | scheduled);
            if (scheduled) begin
                interrupt_source <= next_source; // Latest cause wins while pending.
            end
        end
    end

endmodule

/* logic/interrupt_handler.sv */
`include "ih_settings.svh"

module interrupt_handler
    import ih_irq_pkg::*;
    import ih_io_pkg::*;
(
    input  logic                       clk,
    input  logic                       nrst,
    input  logic [`IH_GPIO_WIDTH-1:0]  gpio_interrupt_pins,
    input  logic [`IH_GPIO_WIDTH-1:0]  gpio_interrupt_mask,
    input  logic                       timer_enable,
    input  logic [`IH_TIMER_WIDTH-1:0] timer_duration,
    input  logic                       interrupt_pin,
    input  logic                       input_handler_enable,
    input  logic [`IH_INPUT_WIDTH-1:0] input_handler_source,
    input  logic                       interrupts_enabled,
    input  logic                       interrupt_ack,
    output logic [`IH_INPUT_WIDTH-1:0] input_handler_output,
    output logic                       interrupt_requested,
    output irq_source_e                interrupt_source
);

    pin_bundle_t  pins_raw;
    pin_bundle_t  pins_sync;
    edge_bundle_t edges;
    logic         timer_fire;

    // One detector per input line plus one for the external pin.
    logic [`IH_INPUT_WIDTH:0] det_in;
    logic [`IH_INPUT_WIDTH:0] det_rise;

    always_comb begin
        pins_raw.input_lines = input_handler_source;
        pins_raw.ext_pin     = interrupt_pin;
        pins_raw.gpio_pins   = gpio_interrupt_pins;
    end

    input_synchronizer i_input_synchronizer (
        .clk       (clk),
        .nrst      (nrst),
        .pins_raw  (pins_raw),
        .pins_sync (pins_sync)
    );

    assign input_handler_output = pins_sync.input_lines;

    // Same bit order as edge_bundle_t, so the rise vector maps straight across.
    assign det_in = {pins_sync.input_lines, pins_sync.ext_pin};

    for (genvar i = 0; i <= `IH_INPUT_WIDTH; i++) begin : g_edge
        edge_detector i_edge_detector (
            .clk         (clk),
            .nrst        (nrst),
            .data_in     (det_in[i]),
            .rising_edge (det_rise[i]),
            .held        ()
        );
    end

    assign edges = edge_bundle_t'(det_rise);

    interval_timer i_interval_timer (
        .clk       (clk),
        .nrst      (nrst),
        .enable    (timer_enable),
        .timer_max (timer_duration),
        .int_fire  (timer_fire)
    );

    interrupt_arbiter i_interrupt_arbiter (
        .clk                 (clk),
        .nrst                (nrst),
        .edges               (edges),
        .gpio_sync           (pins_sync.gpio_pins),
        .gpio_mask           (gpio_interrupt_mask),
        .timer_fire          (timer_fire),
        .input_enable        (input_handler_enable),
        .interrupts_enabled  (interrupts_enabled),
        .interrupt_ack       (interrupt_ack),
        .interrupt_requested (interrupt_requested),
        .interrupt_source    (interrupt_source)
    );

endmodule

/* sim/interrupt_handler_tb.sv */
`include "ih_settings.svh"

module interrupt_handler_tb
    import ih_irq_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD        = 100;
    localparam int RESET_CYCLES  = 16;
    localparam int MARGIN_CYCLES = 20;
    localparam int MAX_STEPS     = 80;
    localparam int LCG_PATTERNS  = 6;
    localparam int TIMER_D       = 5;

    // Everything the testbench drives into the DUT for one step.
    typedef struct packed {
        logic [`IH_INPUT_WIDTH-1:0] lines;
        logic [`IH_GPIO_WIDTH-1:0]  gpio;
        logic [`IH_GPIO_WIDTH-1:0]  mask;
        logic                       ext;
        logic                       tmr_en;
        logic [`IH_TIMER_WIDTH-1:0] duration;
        logic                       in_en;
        logic                       irq_en;
        logic                       ack;
    } stim_t;

    typedef struct packed {
        logic                       req;
        logic                       chk_src;
        irq_source_e                src;
        logic                       chk_out;
        logic [`IH_INPUT_WIDTH-1:0] out;
    } expect_t;

    typedef struct packed {
        logic [3:0] test;
        logic [7:0] cycles;
        stim_t      stim;
        expect_t    exp;
    } step_t;

    logic                       clk;
    logic                       nrst;
    logic [`IH_GPIO_WIDTH-1:0]  gpio_interrupt_pins;
    logic [`IH_GPIO_WIDTH-1:0]  gpio_interrupt_mask;
    logic                       timer_enable;
    logic [`IH_TIMER_WIDTH-1:0] timer_duration;
    logic                       interrupt_pin;
    logic                       input_handler_enable;
    logic [`IH_INPUT_WIDTH-1:0] input_handler_source;
    logic                       interrupts_enabled;
    logic                       interrupt_ack;
    logic [`IH_INPUT_WIDTH-1:0] input_handler_output;
    logic                       interrupt_requested;
    irq_source_e                interrupt_source;

    step_t                      steps [MAX_STEPS];
    int                         n_steps;
    int                         total_cycles;
    logic                       table_ready = 1'b0;
    stim_t                      cur; // Input state while the table is built.
    logic [`IH_INPUT_WIDTH-1:0] last_lines;
    int                         since_change;
    int                         errors;
    int                         test_errors;
    int                         tests_passed;
    int                         tests_failed;

    interrupt_handler i_interrupt_handler (
        .clk                  (clk),
        .nrst                 (nrst),
        .gpio_interrupt_pins  (gpio_interrupt_pins),
        .gpio_interrupt_mask  (gpio_interrupt_mask),
        .timer_enable         (timer_enable),
        .timer_duration       (timer_duration),
        .interrupt_pin        (interrupt_pin),
        .input_handler_enable (input_handler_enable),
        .input_handler_source (input_handler_source),
        .interrupts_enabled   (interrupts_enabled),
        .interrupt_ack        (interrupt_ack),
        .input_handler_output (input_handler_output),
        .interrupt_requested  (interrupt_requested),
        .interrupt_source     (interrupt_source)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "reset state";
            2: return "input bank edges";
            3: return "masked gpio levels";
            4: return "external pin";
            5: return "priority";
            6: return "interval timer";
            default: return "unknown";
        endcase
    endfunction

    // Appends one row for the current input state. The line mirror is only
    // checked once two edges have passed since the lines last changed.
    task automatic add_step(input int test, input int cycles, input logic req,
                            input logic chk_src, input irq_source_e src);
        step_t s;
        if (cur.lines != last_lines) begin
            since_change = cycles;
            last_lines   = cur.lines;
        end else begin
            since_change += cycles;
        end
        s.test        = test[3:0];
        s.cycles      = cycles[7:0];
        s.stim        = cur;
        s.exp.req     = req;
        s.exp.chk_src = chk_src;
        s.exp.src     = src;
        s.exp.chk_out = (since_change >= 2);
        s.exp.out     = cur.lines;
        steps[n_steps] = s;
        n_steps++;
        total_cycles += cycles;
    endtask

    task automatic build_table();
        logic [31:0]                seed;
        logic [`IH_INPUT_WIDTH-1:0] pat;
        logic [`IH_INPUT_WIDTH-1:0] prev;
        logic                       rise;
        cur          = '0;
        cur.in_en    = 1'b1;
        cur.irq_en   = 1'b1;
        last_lines   = '0;
        since_change = 2;
        n_steps      = 0;
        total_cycles = 0;

        add_step(1, 1, 1'b0, 1'b1, timer_is);

        // Any line going from 0 to 1 must raise a request three edges later.
        seed = 32'd70;
        prev = '0;
        for (int i = 0; i < LCG_PATTERNS; i++) begin
            seed = lcg_next(seed);
            pat  = seed[31:16];
            rise = |(pat & ~prev);
            cur.ack   = 1'b0;
            cur.lines = pat;
            add_step(2, 2, 1'b0, 1'b0, timer_is);
            add_step(2, 1, rise, rise, input_is);
            cur.ack = 1'b1;
            add_step(2, 1, 1'b0, 1'b0, timer_is);
            prev = pat;
        end
        cur.ack   = 1'b0;
        cur.in_en = 1'b0;
        cur.lines = '0;
        add_step(2, 3, 1'b0, 1'b0, timer_is);
        cur.lines = prev | 16'h0001; // At least one rising line.
        add_step(2, 3, 1'b0, 1'b0, timer_is);

        cur.in_en = 1'b1;
        cur.gpio  = 8'h10;
        add_step(3, 3, 1'b0, 1'b0, timer_is);
        cur.mask = 8'h10;
        add_step(3, 1, 1'b1, 1'b1, gpio_is);
        cur.mask = 8'h00;
        cur.ack  = 1'b1;
        add_step(3, 1, 1'b0, 1'b0, timer_is);
        cur.ack  = 1'b0;
        cur.gpio = 8'h00;
        add_step(3, 3, 1'b0, 1'b0, timer_is);
        cur.mask = 8'h10;
        add_step(3, 1, 1'b0, 1'b0, timer_is);
        cur.gpio = 8'h10;
        add_step(3, 2, 1'b0, 1'b0, timer_is);
        add_step(3, 1, 1'b1, 1'b1, gpio_is);
        cur.gpio = 8'h00;
        cur.mask = 8'h00;
        cur.ack  = 1'b1;
        add_step(3, 1, 1'b0, 1'b0, timer_is);
        cur.ack = 1'b0;
        add_step(3, 3, 1'b0, 1'b0, timer_is);

        cur.ext = 1'b1;
        add_step(4, 2, 1'b0, 1'b0, timer_is);
        add_step(4, 1, 1'b1, 1'b1, external_is);
        cur.ack = 1'b1;
        add_step(4, 1, 1'b0, 1'b0, timer_is);
        cur.ack = 1'b0;
        add_step(4, 4, 1'b0, 1'b0, timer_is); // Pin still high, no new edge.
        cur.ext = 1'b0;
        add_step(4, 3, 1'b0, 1'b0, timer_is);
        cur.irq_en = 1'b0;
        cur.ext    = 1'b1;
        add_step(4, 3, 1'b0, 1'b0, timer_is);
        add_step(4, 2, 1'b0, 1'b0, timer_is);
        cur.irq_en = 1'b1;
        add_step(4, 2, 1'b0, 1'b0, timer_is);

        // With a duration of 1 the timer fires in the same cycle as the
        // input rise and the synchronized GPIO level.
        cur.lines = '0;
        add_step(5, 3, 1'b0, 1'b0, timer_is);
        cur.lines    = 16'h00ff;
        cur.gpio     = 8'h01;
        cur.mask     = 8'h01;
        cur.tmr_en   = 1'b1;
        cur.duration = 32'd1;
        add_step(5, 3, 1'b1, 1'b1, timer_is);
        cur.tmr_en = 1'b0;
        cur.gpio   = 8'h00;
        cur.mask   = 8'h00;
        cur.ack    = 1'b1;
        add_step(5, 1, 1'b0, 1'b0, timer_is);
        cur.ack   = 1'b0;
        cur.lines = '0;
        add_step(5, 3, 1'b0, 1'b0, timer_is);
        cur.lines = 16'h0f0f;
        cur.gpio  = 8'h02;
        cur.mask  = 8'h02;
        add_step(5, 3, 1'b1, 1'b1, input_is);
        cur.gpio = 8'h00;
        cur.mask = 8'h00;
        cur.ack  = 1'b1;
        add_step(5, 1, 1'b0, 1'b0, timer_is);
        cur.ack = 1'b0;
        add_step(5, 3, 1'b0, 1'b0, timer_is);

        cur.tmr_en   = 1'b1;
        cur.duration = TIMER_D;
        add_step(6, TIMER_D + 1, 1'b0, 1'b0, timer_is);
        add_step(6, 1, 1'b1, 1'b1, timer_is);
        cur.ack = 1'b1;
        add_step(6, 1, 1'b0, 1'b0, timer_is);
        cur.ack = 1'b0;
        add_step(6, TIMER_D - 1, 1'b0, 1'b0, timer_is);
        add_step(6, 1, 1'b1, 1'b1, timer_is); // One period after the first.
        add_step(6, 3, 1'b1, 1'b1, timer_is);
        cur.tmr_en = 1'b0;
        cur.ack    = 1'b1;
        add_step(6, 1, 1'b0, 1'b0, timer_is);
        cur.ack = 1'b0;
        add_step(6, TIMER_D + 3, 1'b0, 1'b0, timer_is);
    endtask

    task automatic apply_stim(input stim_t s);
        input_handler_source = s.lines;
        gpio_interrupt_pins  = s.gpio;
        gpio_interrupt_mask  = s.mask;
        interrupt_pin        = s.ext;
        timer_enable         = s.tmr_en;
        timer_duration       = s.duration;
        input_handler_enable = s.in_en;
        interrupts_enabled   = s.irq_en;
        interrupt_ack        = s.ack;
    endtask

    task automatic check_step(input int idx);
        expect_t e;
        e = steps[idx].exp;
        if (interrupt_requested !== e.req) begin
            $display("** Error: step %0d interrupt_requested expected %h got %h",
                     idx, e.req, interrupt_requested);
            test_errors++;
        end
        if (e.chk_src && interrupt_source !== e.src) begin
            $display("** Error: step %0d interrupt_source expected %h got %h",
                     idx, e.src, interrupt_source);
            test_errors++;
        end
        if (e.chk_out && input_handler_output !== e.out) begin
            $display("** Error: step %0d input_handler_output expected %h got %h",
                     idx, e.out, input_handler_output);
            test_errors++;
        end
    endtask

    task automatic report_test(input int id);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", id, test_name(id));
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", id, test_name(id), test_errors);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        clk          = 1'b0;
        nrst         = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        apply_stim('0);
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        nrst = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            apply_stim(steps[i].stim);
            repeat (steps[i].cycles) @(posedge clk);
            #5; // Registered outputs have settled well before the next edge.
            check_step(i);
            #5;
            if (i == n_steps - 1 || steps[i+1].test != steps[i].test) begin
                report_test(steps[i].test);
            end
        end
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((total_cycles + RESET_CYCLES + MARGIN_CYCLES) * PERIOD);
        $display("Timeout: the step table did not finish within %0d cycles",
                 total_cycles + RESET_CYCLES + MARGIN_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+logic
logic/ih_irq_pkg.sv
logic/ih_io_pkg.sv
logic/input_synchronizer.sv
logic/edge_detector.sv
logic/interval_timer.sv
logic/interrupt_arbiter.sv
logic/interrupt_handler.sv
sim/interrupt_handler_tb.sv
